// File: design/ecc_correct.sv
//******************************
// check path execute stage
// fixes single errors, flags double
// errors and registers the result
//******************************
`default_nettype none
`timescale 1ns/10ps

module ecc_correct (
   input  logic                    clk,
   input  logic                    rst_l,
   input  ecc_pkg::syndrome_t      syn,
   output ecc_pkg::check_result_t  chk_result
);

   ecc_pkg::code_word_t          code_in;
   logic [ecc_pkg::CODE_POS-1:0] ham_word;     // index p-1 holds hamming position p
   logic [ecc_pkg::CODE_POS-1:0] flip_mask;
   logic [ecc_pkg::CODE_POS-1:0] fixed_word;
   ecc_pkg::code_word_t          code_fixed;
   logic                         any_err;
   logic                         single_d;
   logic                         double_d;

   logic                         valid_q;
   logic                         single_q;
   logic                         double_q;
   ecc_pkg::code_word_t          code_q;

   assign code_in = syn.code;

   // scatter into position order, check bit k sits at 2^k
   always_comb begin
      int d;
      int k;
      d        = 0;
      k        = 0;
      ham_word = '0;
      for (int p = 1; p < ecc_pkg::CODE_POS; p++) begin
         if ((p & (p - 1)) == 0) begin
            ham_word[p-1] = code_in.ecc[k];
            k++;
         end else begin
            ham_word[p-1] = code_in.data[d];
            d++;
         end
      end
      ham_word[ecc_pkg::CODE_POS-1] = code_in.ecc[ecc_pkg::ECC_W-1];
   end

   // one-hot on the failing position, 39..63 select nothing
   always_comb begin
      flip_mask = '0;
      for (int p = 1; p < ecc_pkg::CODE_POS; p++) begin
         flip_mask[p-1] = (int'(syn.syndrome) == p);
      end
      flip_mask[ecc_pkg::CODE_POS-1] = (syn.syndrome == '0);   // only the overall bit is bad
   end

   assign any_err    = syn.valid & ((syn.syndrome != '0) | syn.overall);
   assign single_d   = any_err & syn.overall;
   assign double_d   = any_err & ~syn.overall;
   assign fixed_word = single_d ? (ham_word ^ flip_mask) : ham_word;

   // gather back to data and check bits
   always_comb begin
      int d;
      int k;
      d          = 0;
      k          = 0;
      code_fixed = '0;
      for (int p = 1; p < ecc_pkg::CODE_POS; p++) begin
         if ((p & (p - 1)) == 0) begin
            code_fixed.ecc[k] = fixed_word[p-1];
            k++;
         end else begin
            code_fixed.data[d] = fixed_word[p-1];
            d++;
         end
      end
      code_fixed.ecc[ecc_pkg::ECC_W-1] = fixed_word[ecc_pkg::CODE_POS-1];
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         valid_q  <= 1'b0;
         single_q <= 1'b0;
         double_q <= 1'b0;
      end else begin
         valid_q  <= syn.valid;
         single_q <= single_d;
         double_q <= double_d;
      end
   end

   always_ff @(posedge clk) begin
      if (syn.valid) code_q <= code_fixed;
   end

   assign chk_result = '{valid:      valid_q,
                         single_err: single_q,
                         double_err: double_q,
                         code:       code_q};

   a_err_exclusive: assert property (
      @(posedge clk) disable iff (!rst_l)
      !(chk_result.single_err && chk_result.double_err)
   ) else $error("single and double error flagged together");

endmodule

`default_nettype wire

// File: design/ecc_encoder.sv
//******************************
// write path encoder, one cycle
// data word in, 39-bit codeword out
//******************************
`default_nettype none
`timescale 1ns/10ps

module ecc_encoder (
   input  logic                       clk,
   input  logic                       rst_l,
   input  logic                       wr_valid,
   input  logic [ecc_pkg::DATA_W-1:0] wr_data,
   output logic                       enc_valid,
   output ecc_pkg::code_word_t        enc_code
);

   logic [ecc_pkg::SYN_W-1:0] ham_bits;
   logic                      overall;

   // one masked parity per hamming check bit
   always_comb begin
      for (int i = 0; i < ecc_pkg::SYN_W; i++) begin
         ham_bits[i] = ^(wr_data & ecc_pkg::CHECK_MASK[i]);
      end
   end

   assign overall = (^wr_data) ^ (^ham_bits);   // makes the whole word even

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         enc_valid <= 1'b0;
      end else begin
         enc_valid <= wr_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_valid) begin
         enc_code.data <= wr_data;
         enc_code.ecc  <= {overall, ham_bits};
      end
   end

   // any valid codeword leaves with even parity over all 39 bits
   a_enc_even_parity: assert property (
      @(posedge clk) disable iff (!rst_l)
      enc_valid |-> !(^enc_code)
   ) else $error("encoder produced odd parity codeword %h", enc_code);

endmodule

`default_nettype wire

// File: design/ecc_pkg.sv
//******************************
// widths, Hamming check masks and pipeline
// structs for the 32-bit SECDED block
//******************************
`default_nettype none

package ecc_pkg;

   localparam int DATA_W   = 32;
   localparam int ECC_W    = 7;    // 6 hamming bits + overall parity
   localparam int SYN_W    = 6;
   localparam int CODE_POS = 39;   // positions 1..38 plus the overall bit

   // check bit i covers the data bits whose hamming position has bit i set.
   // data fills positions 3,5,6,7,9,... so data bit 0 lands on position 3
   localparam logic [SYN_W-1:0][DATA_W-1:0] CHECK_MASK = '{
      32'hFC00_0000,   // [5] positions 32..38
      32'h03FF_F800,   // [4] positions 16..31
      32'h03FC_07F0,   // [3]
      32'hE3C3_C78E,   // [2]
      32'h9B33_366D,   // [1]
      32'h56AA_AD5B    // [0]
   };

   // stored memory word
   typedef struct packed {
      logic [ECC_W-1:0]  ecc;    // [6] is the overall parity
      logic [DATA_W-1:0] data;
   } code_word_t;

   // request into the check path
   typedef struct packed {
      logic       valid;
      logic       sed_ded;      // detect only, overall parity ignored
      code_word_t code;
   } check_req_t;

   // decode to execute register
   typedef struct packed {
      logic             valid;
      logic             sed_ded;
      logic [SYN_W-1:0] syndrome;   // failing hamming position
      logic             overall;    // parity over all 39 bits
      code_word_t       code;       // as received
   } syndrome_t;

   // check path output
   typedef struct packed {
      logic       valid;
      logic       single_err;   // corrected
      logic       double_err;   // uncorrectable, code passed through
      code_word_t code;
   } check_result_t;

endpackage

`default_nettype wire

// File: design/ecc_syndrome.sv
//******************************
// check path decode stage
// registers syndrome, overall parity
// and the received codeword
//******************************
`default_nettype none
`timescale 1ns/10ps

module ecc_syndrome (
   input  logic                  clk,
   input  logic                  rst_l,
   input  ecc_pkg::check_req_t   chk_req,
   output ecc_pkg::syndrome_t    syn
);

   ecc_pkg::code_word_t       code_in;
   logic [ecc_pkg::SYN_W-1:0] syndrome_d;
   logic                      overall_d;

   logic                      valid_q;
   logic                      sed_ded_q;
   logic [ecc_pkg::SYN_W-1:0] syndrome_q;
   logic                      overall_q;
   ecc_pkg::code_word_t       code_q;

   assign code_in = chk_req.code;

   // received check bit against the recomputed one
   always_comb begin
      for (int i = 0; i < ecc_pkg::SYN_W; i++) begin
         syndrome_d[i] = code_in.ecc[i] ^ (^(code_in.data & ecc_pkg::CHECK_MASK[i]));
      end
   end

   // detect-only mode drops the overall bit, so every error looks double
   assign overall_d = ((^code_in.data) ^ (^code_in.ecc)) & ~chk_req.sed_ded;

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= chk_req.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (chk_req.valid) begin
         sed_ded_q  <= chk_req.sed_ded;
         syndrome_q <= syndrome_d;
         overall_q  <= overall_d;
         code_q     <= code_in;
      end
   end

   assign syn = '{valid:    valid_q,
                  sed_ded:  sed_ded_q,
                  syndrome: syndrome_q,
                  overall:  overall_q,
                  code:     code_q};

   // execute stage must never see a single error in detect-only mode
   a_sed_ded_no_overall: assert property (
      @(posedge clk) disable iff (!rst_l)
      (syn.valid && syn.sed_ded) |-> !syn.overall
   ) else $error("overall parity set in detect-only mode");

endmodule

`default_nettype wire

// File: design/ecc_top.sv
//******************************
// SECDED top, write path encoder
// plus the two-stage check pipeline
//******************************
`default_nettype none
`timescale 1ns/10ps

module ecc_top (
   input  logic                       clk,
   input  logic                       rst_l,
   // write path
   input  logic                       wr_valid,
   input  logic [ecc_pkg::DATA_W-1:0] wr_data,
   output logic                       enc_valid,
   output ecc_pkg::code_word_t        enc_code,
   // check path, result two cycles after request
   input  ecc_pkg::check_req_t        chk_req,
   output ecc_pkg::check_result_t     chk_result
);

   ecc_pkg::syndrome_t syn;   // decode -> execute

   ecc_encoder u_encoder (
      .clk       (clk),
      .rst_l     (rst_l),
      .wr_valid  (wr_valid),
      .wr_data   (wr_data),
      .enc_valid (enc_valid),
      .enc_code  (enc_code)
   );

   ecc_syndrome u_syndrome (
      .clk     (clk),
      .rst_l   (rst_l),
      .chk_req (chk_req),
      .syn     (syn)
   );

   ecc_correct u_correct (
      .clk        (clk),
      .rst_l      (rst_l),
      .syn        (syn),
      .chk_result (chk_result)
   );

endmodule

`default_nettype wire

// File: list.f
+incdir+verif
design/ecc_pkg.sv
design/ecc_encoder.sv
design/ecc_syndrome.sv
design/ecc_correct.sv
design/ecc_top.sv
verif/ecc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the SECDED testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --top-module ecc_tb \
   -f list.f \
   -o ecc_sim

./obj_dir/ecc_sim | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
   echo "run.sh: simulation ok"
   exit 0
else
   echo "run.sh: simulation reported failure"
   exit 1
fi

// File: verif/ecc_model.svh
//******************************
// reference model for the SECDED testbench
// encodes from the hamming position rule, flips bits,
// predicts check results and supplies xorshift numbers
//******************************
`ifndef ECC_MODEL_SVH
`define ECC_MODEL_SVH

logic [31:0] rand_state = 32'd21;   // seed

// xorshift32, one step per call
function automatic logic [31:0] next_random();
   logic [31:0] x;
   x = rand_state;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   rand_state = x;
   return x;
endfunction

function automatic int random_index(input int n);
   return int'(next_random() % 32'(n));
endfunction

// hamming position of data bit n, powers of two are skipped
function automatic int data_position(input int bit_idx);
   int pos;
   int seen;
   pos  = 0;
   seen = -1;
   while (seen < bit_idx) begin
      pos++;
      if ((pos & (pos - 1)) != 0) seen++;
   end
   return pos;
endfunction

function automatic ecc_pkg::code_word_t encode_word(input logic [31:0] data);
   ecc_pkg::code_word_t cw;
   int                  pos;
   cw.data = data;
   cw.ecc  = '0;
   for (int i = 0; i < 32; i++) begin
      pos = data_position(i);
      for (int k = 0; k < 6; k++) begin
         if (data[i] && (((pos >> k) & 1) != 0)) cw.ecc[k] = cw.ecc[k] ^ 1'b1;
      end
   end
   cw.ecc[6] = ^{cw.ecc[5:0], data};   // even parity over all 39 bits
   return cw;
endfunction

// flat index, 0..31 data, 32..38 check bits
function automatic ecc_pkg::code_word_t flip_bits(input ecc_pkg::code_word_t code,
                                                  input int idx);
   return code ^ (39'd1 << idx);
endfunction

function automatic ecc_pkg::code_word_t flip_two_bits(input ecc_pkg::code_word_t code);
   int b1;
   int b2;
   b1 = random_index(39);
   b2 = random_index(38);
   if (b2 >= b1) b2++;   // always distinct
   return flip_bits(flip_bits(code, b1), b2);
endfunction

// expected result for up to two flipped bits
function automatic ecc_pkg::check_result_t expect_check(input ecc_pkg::code_word_t orig,
                                                        input ecc_pkg::code_word_t rx,
                                                        input logic sed_ded);
   ecc_pkg::check_result_t r;
   logic [38:0]            diff_bits;
   int                     n_diff;
   diff_bits    = orig ^ rx;
   n_diff       = $countones(diff_bits);
   r.valid      = 1'b1;
   r.single_err = 1'b0;
   r.double_err = 1'b0;
   r.code       = rx;
   if (n_diff == 1 && !sed_ded) begin
      r.single_err = 1'b1;
      r.code       = orig;
   end else if (n_diff == 1) begin
      // detect only, a lone overall bit flip goes unseen
      if (!diff_bits[38]) r.double_err = 1'b1;
   end else if (n_diff == 2) begin
      r.double_err = 1'b1;
   end
   return r;
endfunction

`endif

// File: verif/ecc_tb.sv
//******************************
// directed testbench for the SECDED block,
// drives ecc_top and checks against ecc_model.svh
//******************************
`default_nettype none
`timescale 1ns/10ps

module ecc_tb;

   localparam int RESET_CYCLES   = 16;
   localparam int STREAM_LEN     = 300;
   // 1870 items at up to 3 cycles each need about 5600 cycles
   localparam int TIMEOUT_CYCLES = 20000;

   logic                       clk;
   logic                       rst_l;
   logic                       wr_valid;
   logic [ecc_pkg::DATA_W-1:0] wr_data;
   logic                       enc_valid;
   ecc_pkg::code_word_t        enc_code;
   ecc_pkg::check_req_t        chk_req;
   ecc_pkg::check_result_t     chk_result;

   int error_cnt = 0;
   int check_cnt = 0;
   int test_cnt  = 0;
   int cycle_cnt;

   `include "ecc_model.svh"

   ecc_top uut (
      .clk        (clk),
      .rst_l      (rst_l),
      .wr_valid   (wr_valid),
      .wr_data    (wr_data),
      .enc_valid  (enc_valid),
      .enc_code   (enc_code),
      .chk_req    (chk_req),
      .chk_result (chk_result)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns
   end

   initial begin
      for (cycle_cnt = 0; cycle_cnt < TIMEOUT_CYCLES; cycle_cnt++) begin
         @(posedge clk);
      end
      $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
   end

   task automatic compare_code(input string name, input ecc_pkg::code_word_t got,
                               input ecc_pkg::code_word_t exp);
      check_cnt++;
      if (got !== exp) begin
         error_cnt++;
         $display("Mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic compare_result(input string name, input ecc_pkg::check_result_t got,
                                 input ecc_pkg::check_result_t exp);
      check_cnt++;
      if (got.valid !== 1'b1) begin
         error_cnt++;
         $display("%s: no valid result two cycles after the request", name);
      end else begin
         if (got.single_err !== exp.single_err) begin
            error_cnt++;
            $display("Mismatch %s.single_err: got %h expected %h", name,
                     got.single_err, exp.single_err);
         end
         if (got.double_err !== exp.double_err) begin
            error_cnt++;
            $display("Mismatch %s.double_err: got %h expected %h", name,
                     got.double_err, exp.double_err);
         end
         compare_code({name, ".code"}, got.code, exp.code);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      test_cnt++;
      if (error_cnt == errs_before) $display("%s: ok", name);
      else $display("%s: %0d errors", name, error_cnt - errs_before);
   endtask

   task automatic encode_one(input logic [31:0] data);
      ecc_pkg::code_word_t exp;
      exp = encode_word(data);
      @(posedge clk);
      wr_valid <= 1'b1;
      wr_data  <= data;
      @(posedge clk);
      wr_valid <= 1'b0;
      @(negedge clk);
      if (enc_valid !== 1'b1) begin
         check_cnt++;
         error_cnt++;
         $display("enc_valid missing one cycle after wr_valid, data %h", data);
      end else begin
         compare_code("enc_code", enc_code, exp);
      end
   endtask

   // single request whose result is due exactly two cycles later
   task automatic check_one(input ecc_pkg::code_word_t rx, input logic sed_ded,
                            input ecc_pkg::check_result_t exp);
      ecc_pkg::check_req_t req;
      req.valid   = 1'b1;
      req.sed_ded = sed_ded;
      req.code    = rx;
      @(posedge clk);
      chk_req <= req;
      @(posedge clk);
      chk_req.valid <= 1'b0;
      @(negedge clk);
      if (chk_result.valid !== 1'b0) begin
         error_cnt++;
         $display("chk_result valid one cycle early for code %h", rx);
      end
      @(posedge clk);
      @(negedge clk);
      compare_result("chk_result", chk_result, exp);
   endtask

   task automatic test_encode();
      int errs_before;
      errs_before = error_cnt;
      encode_one(32'h0000_0000);
      encode_one(32'hFFFF_FFFF);
      for (int i = 0; i < 32; i++) encode_one(32'd1 << i);
      repeat (200) encode_one(next_random());
      report_test("test_encode", errs_before);
   endtask

   task automatic test_clean();
      int                  errs_before;
      ecc_pkg::code_word_t orig;
      errs_before = error_cnt;
      repeat (200) begin
         orig = encode_word(next_random());
         check_one(orig, 1'b0, expect_check(orig, orig, 1'b0));
      end
      report_test("test_clean", errs_before);
   endtask

   task automatic test_single();
      int                  errs_before;
      ecc_pkg::code_word_t orig;
      ecc_pkg::code_word_t rx;
      errs_before = error_cnt;
      repeat (20) begin
         orig = encode_word(next_random());
         for (int b = 0; b < ecc_pkg::CODE_POS; b++) begin
            rx = flip_bits(orig, b);
            check_one(rx, 1'b0, expect_check(orig, rx, 1'b0));
         end
      end
      report_test("test_single", errs_before);
   endtask

   task automatic test_double();
      int                  errs_before;
      ecc_pkg::code_word_t orig;
      ecc_pkg::code_word_t rx;
      errs_before = error_cnt;
      repeat (200) begin
         orig = encode_word(next_random());
         rx   = flip_two_bits(orig);
         check_one(rx, 1'b0, expect_check(orig, rx, 1'b0));
      end
      report_test("test_double", errs_before);
   endtask

   task automatic test_sed_ded();
      int                  errs_before;
      ecc_pkg::code_word_t orig;
      ecc_pkg::code_word_t rx;
      errs_before = error_cnt;
      repeat (20) begin
         orig = encode_word(next_random());
         check_one(orig, 1'b1, expect_check(orig, orig, 1'b1));
      end
      repeat (2) begin
         orig = encode_word(next_random());
         for (int b = 0; b < ecc_pkg::CODE_POS - 1; b++) begin   // bit 38 has no syndrome
            rx = flip_bits(orig, b);
            check_one(rx, 1'b1, expect_check(orig, rx, 1'b1));
         end
      end
      repeat (60) begin
         orig = encode_word(next_random());
         rx   = flip_two_bits(orig);
         check_one(rx, 1'b1, expect_check(orig, rx, 1'b1));
      end
      report_test("test_sed_ded", errs_before);
   endtask

   // back to back requests with results one per cycle in order
   task automatic test_stream();
      int                     errs_before;
      int                     kind;
      ecc_pkg::code_word_t    orig;
      ecc_pkg::code_word_t    rx;
      ecc_pkg::check_req_t    stream_req [STREAM_LEN];
      ecc_pkg::check_result_t stream_exp [STREAM_LEN];
      errs_before = error_cnt;
      for (int i = 0; i < STREAM_LEN; i++) begin
         orig = encode_word(next_random());
         kind = random_index(4);
         case (kind)
            0:       rx = orig;
            1:       rx = flip_bits(orig, random_index(ecc_pkg::CODE_POS));
            2:       rx = flip_two_bits(orig);
            default: rx = (random_index(2) == 0) ? flip_bits(orig, random_index(38))
                                                 : flip_two_bits(orig);
         endcase
         stream_req[i].valid   = 1'b1;
         stream_req[i].sed_ded = (kind == 3);
         stream_req[i].code    = rx;
         stream_exp[i]         = expect_check(orig, rx, kind == 3);
      end
      for (int i = 0; i < STREAM_LEN + 2; i++) begin
         @(posedge clk);
         if (i < STREAM_LEN) chk_req <= stream_req[i];
         else chk_req <= '0;
         @(negedge clk);
         if (i >= 2) begin
            compare_result($sformatf("chk_result[%0d]", i - 2), chk_result, stream_exp[i-2]);
         end else if (chk_result.valid !== 1'b0) begin
            error_cnt++;
            $display("chk_result valid before the first streamed request could finish");
         end
      end
      @(posedge clk);
      @(negedge clk);
      if (chk_result.valid !== 1'b0) begin
         error_cnt++;
         $display("chk_result still valid after the last streamed result");
      end
      report_test("test_stream", errs_before);
   endtask

   initial begin
      rst_l    <= 1'b0;
      wr_valid <= 1'b0;
      wr_data  <= '0;
      chk_req  <= '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_l <= 1'b1;
      @(negedge clk);
      check_cnt++;
      if (enc_valid !== 1'b0 || chk_result.valid !== 1'b0) begin
         error_cnt++;
         $display("valid outputs not cleared by reset");
      end
      test_encode();
      test_clean();
      test_single();
      test_double();
      test_sed_ded();
      test_stream();
      $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
      if (error_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
